//--- src/shell_cfg_pkg.sv
// **********************************************************************
// Sizes and instruction encodings shared by the trace pipeline shell
// **********************************************************************

`default_nettype none

package shell_cfg_pkg;

    // Instruction word and program counter width
    localparam int XLEN = 32;

    // Width of the retirement order counter
    localparam int ORDER_W = 16;

    // Register index width of the base integer ISA
    localparam int REG_ADDR_W = 5;

    // Low opcode bits of every 32-bit instruction; anything else is compressed
    localparam logic [1:0] OPC_LOW_LEGAL = 2'b11;

    // Low bit positions of the rd and rs1 fields
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;

endpackage

`default_nettype wire

//--- src/shell_trace_pkg.sv
// **********************************************************************
// Trace record field types and the controller state of the shell
// **********************************************************************

`default_nettype none

package shell_trace_pkg;

    import shell_cfg_pkg::*;

    // Instruction word as seen in the trace
    typedef logic [XLEN-1:0] insn_t;

    // Program counter of the retired instruction
    typedef logic [XLEN-1:0] pc_t;

    // Architectural register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Retirement number, dense over retired records
    typedef logic [ORDER_W-1:0] order_t;

    // Interrupt tracking in the controller
    // CTRL_IRQ_PEND waits for the next accepted record to carry the mark
    typedef enum logic {
        CTRL_RUN,
        CTRL_IRQ_PEND
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- src/controller.sv
// **********************************************************************
// Central pipeline control that computes step and flush per stage, input
// ready and the interrupt mark of the next accepted trace record
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module controller (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic in_valid_i,
    input  logic irq_i,
    input  logic if_valid_i,
    input  logic id_valid_i,
    input  logic ex_valid_i,
    input  logic ex_trap_i,
    input  logic wb_valid_i,
    input  logic out_ready_i,
    output logic if_step_o,
    output logic id_step_o,
    output logic ex_step_o,
    output logic wb_step_o,
    output logic if_flush_o,
    output logic id_flush_o,
    output logic in_ready_o,
    output logic if_intr_o,
    output logic irq_ack_o
);

    import shell_trace_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        irq_q;
    logic        irq_rise;
    logic        trap_flush;
    logic        accept;

    // Step chain built from the sink backwards
    // A stage moves when it is empty or its successor moves
    assign wb_step_o = !wb_valid_i || out_ready_i;
    assign ex_step_o = !ex_valid_i || wb_step_o;
    assign id_step_o = !id_valid_i || ex_step_o;
    assign if_step_o = !if_valid_i || id_step_o;

    // A trapping record in EX kills everything younger in IF and ID
    assign trap_flush = ex_valid_i && ex_trap_i;
    assign if_flush_o = trap_flush;
    assign id_flush_o = trap_flush;

    // No new record may enter while the younger ones are being killed
    assign in_ready_o = if_step_o && !trap_flush;
    assign accept     = in_valid_i && in_ready_o;

    assign irq_rise = irq_i && !irq_q;

    // The mark is offered to IF while pending and taken on acceptance
    assign if_intr_o = (state_q == CTRL_IRQ_PEND);
    assign irq_ack_o = (state_q == CTRL_IRQ_PEND) && accept;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_RUN: begin
                if (irq_rise) begin
                    state_d = CTRL_IRQ_PEND;
                end
            end
            CTRL_IRQ_PEND: begin
                if (accept) begin
                    state_d = CTRL_RUN;
                end
            end
            default: begin
                state_d = CTRL_RUN;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= CTRL_RUN;
            irq_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            irq_q   <= irq_i;
        end
    end

    // Only one record can be marked per interrupt edge
    a_irq_ack_single : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        irq_ack_o |=> !irq_ack_o
    );

    // A record taken from the source always lands in IF, which keeps the
    // input closed while the younger stages are being killed
    a_accept_lands_in_if : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        accept |=> if_valid_i
    );

endmodule

`default_nettype wire

//--- src/if_stage.sv
// **********************************************************************
// Fetch stage of the trace model: holds the record just accepted from
// the source together with its interrupt mark
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   step_i,
    input  logic                   flush_i,
    input  logic                   in_valid_i,
    input  shell_trace_pkg::insn_t in_insn_i,
    input  shell_trace_pkg::pc_t   in_pc_i,
    input  logic                   intr_i,
    output logic                   valid_o,
    output shell_trace_pkg::insn_t insn_o,
    output shell_trace_pkg::pc_t   pc_o,
    output logic                   intr_o
);

    import shell_trace_pkg::*;

    // A step with no valid input leaves the stage empty
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (step_i) begin
            valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step_i && in_valid_i) begin
            insn_o <= in_insn_i;
            pc_o   <= in_pc_i;
            intr_o <= intr_i;
        end
    end

endmodule

`default_nettype wire

//--- src/id_stage.sv
// **********************************************************************
// Decode stage: passes the record on and extracts rd and rs1 indices
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       step_i,
    input  logic                       flush_i,
    input  logic                       valid_i,
    input  shell_trace_pkg::insn_t     insn_i,
    input  shell_trace_pkg::pc_t       pc_i,
    input  logic                       intr_i,
    output logic                       valid_o,
    output shell_trace_pkg::insn_t     insn_o,
    output shell_trace_pkg::pc_t       pc_o,
    output logic                       intr_o,
    output shell_trace_pkg::reg_addr_t rd_addr_o,
    output shell_trace_pkg::reg_addr_t rs1_addr_o
);

    import shell_cfg_pkg::*;
    import shell_trace_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (step_i) begin
            valid_o <= valid_i;
        end
    end

    // Field positions are the same for every 32-bit format that has them
    always_ff @(posedge clk_i) begin
        if (step_i && valid_i) begin
            insn_o     <= insn_i;
            pc_o       <= pc_i;
            intr_o     <= intr_i;
            rd_addr_o  <= insn_i[RD_LSB +: REG_ADDR_W];
            rs1_addr_o <= insn_i[RS1_LSB +: REG_ADDR_W];
        end
    end

endmodule

`default_nettype wire

//--- src/ex_stage.sv
// **********************************************************************
// Execute stage: flags illegal instructions as traps; a trapping record
// here triggers the flush of the younger stages in the controller
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       step_i,
    input  logic                       valid_i,
    input  shell_trace_pkg::insn_t     insn_i,
    input  shell_trace_pkg::pc_t       pc_i,
    input  logic                       intr_i,
    input  shell_trace_pkg::reg_addr_t rd_addr_i,
    input  shell_trace_pkg::reg_addr_t rs1_addr_i,
    output logic                       valid_o,
    output shell_trace_pkg::insn_t     insn_o,
    output shell_trace_pkg::pc_t       pc_o,
    output logic                       intr_o,
    output shell_trace_pkg::reg_addr_t rd_addr_o,
    output shell_trace_pkg::reg_addr_t rs1_addr_o,
    output logic                       trap_o
);

    import shell_cfg_pkg::*;
    import shell_trace_pkg::*;

    logic illegal;
    logic kill_in;

    // Compressed encodings are not supported and count as illegal
    assign illegal = (insn_i[1:0] != OPC_LOW_LEGAL);

    // While the trap sits here the record behind it in ID is younger
    // and must not slip into EX as the trap moves on
    assign kill_in = valid_o && trap_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (step_i) begin
            valid_o <= valid_i && !kill_in;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step_i && valid_i) begin
            insn_o     <= insn_i;
            pc_o       <= pc_i;
            intr_o     <= intr_i;
            trap_o     <= illegal;
            rs1_addr_o <= rs1_addr_i;
            // A trapping instruction writes no register
            rd_addr_o  <= illegal ? '0 : rd_addr_i;
        end
    end

endmodule

`default_nettype wire

//--- src/wb_stage.sv
// **********************************************************************
// Writeback stage and output register of the shell; numbers each
// retiring record and holds it while the sink stalls
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       step_i,
    input  logic                       valid_i,
    input  shell_trace_pkg::insn_t     insn_i,
    input  shell_trace_pkg::pc_t       pc_i,
    input  logic                       intr_i,
    input  shell_trace_pkg::reg_addr_t rd_addr_i,
    input  shell_trace_pkg::reg_addr_t rs1_addr_i,
    input  logic                       trap_i,
    output logic                       valid_o,
    output shell_trace_pkg::order_t    order_o,
    output shell_trace_pkg::insn_t     insn_o,
    output shell_trace_pkg::pc_t       pc_o,
    output logic                       intr_o,
    output shell_trace_pkg::reg_addr_t rd_addr_o,
    output shell_trace_pkg::reg_addr_t rs1_addr_o,
    output logic                       trap_o
);

    import shell_trace_pkg::*;

    order_t order_cnt;
    logic   load;

    assign load = step_i && valid_i;

    // Counter only advances on a real load, so killed records leave no gap
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o   <= 1'b0;
            order_cnt <= '0;
        end else if (step_i) begin
            valid_o <= valid_i;
            if (valid_i) begin
                order_cnt <= order_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            order_o    <= order_cnt;
            insn_o     <= insn_i;
            pc_o       <= pc_i;
            intr_o     <= intr_i;
            rd_addr_o  <= rd_addr_i;
            rs1_addr_o <= rs1_addr_i;
            trap_o     <= trap_i;
        end
    end

    // A stalled record must be presented unchanged until the sink takes it
    a_hold_on_stall : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (valid_o && !step_i) |=> (valid_o && $stable({order_o, insn_o, pc_o, intr_o,
                                                      rd_addr_o, rs1_addr_o, trap_o}))
    );

endmodule

`default_nettype wire

//--- src/pipeline_shell.sv
// **********************************************************************
// Top of the trace pipeline shell; replays accepted trace records
// through IF, ID, EX and WB under control of the central controller
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module pipeline_shell (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  shell_trace_pkg::insn_t     in_insn_i,
    input  shell_trace_pkg::pc_t       in_pc_i,
    input  logic                       irq_i,
    output logic                       irq_ack_o,
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output shell_trace_pkg::order_t    out_order_o,
    output shell_trace_pkg::insn_t     out_insn_o,
    output shell_trace_pkg::pc_t       out_pc_o,
    output shell_trace_pkg::reg_addr_t out_rd_addr_o,
    output shell_trace_pkg::reg_addr_t out_rs1_addr_o,
    output logic                       out_trap_o,
    output logic                       out_intr_o
);

    import shell_trace_pkg::*;

    logic      if_step;
    logic      id_step;
    logic      ex_step;
    logic      wb_step;
    logic      if_flush;
    logic      id_flush;
    logic      if_intr_mark;

    logic      if_valid;
    insn_t     if_insn;
    pc_t       if_pc;
    logic      if_intr;

    logic      id_valid;
    insn_t     id_insn;
    pc_t       id_pc;
    logic      id_intr;
    reg_addr_t id_rd_addr;
    reg_addr_t id_rs1_addr;

    logic      ex_valid;
    insn_t     ex_insn;
    pc_t       ex_pc;
    logic      ex_intr;
    reg_addr_t ex_rd_addr;
    reg_addr_t ex_rs1_addr;
    logic      ex_trap;

    logic      wb_valid;

    assign out_valid_o = wb_valid;

    controller controller_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .irq_i       (irq_i),
        .if_valid_i  (if_valid),
        .id_valid_i  (id_valid),
        .ex_valid_i  (ex_valid),
        .ex_trap_i   (ex_trap),
        .wb_valid_i  (wb_valid),
        .out_ready_i (out_ready_i),
        .if_step_o   (if_step),
        .id_step_o   (id_step),
        .ex_step_o   (ex_step),
        .wb_step_o   (wb_step),
        .if_flush_o  (if_flush),
        .id_flush_o  (id_flush),
        .in_ready_o  (in_ready_o),
        .if_intr_o   (if_intr_mark),
        .irq_ack_o   (irq_ack_o)
    );

    if_stage if_stage_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .step_i     (if_step),
        .flush_i    (if_flush),
        .in_valid_i (in_valid_i),
        .in_insn_i  (in_insn_i),
        .in_pc_i    (in_pc_i),
        .intr_i     (if_intr_mark),
        .valid_o    (if_valid),
        .insn_o     (if_insn),
        .pc_o       (if_pc),
        .intr_o     (if_intr)
    );

    id_stage id_stage_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .step_i     (id_step),
        .flush_i    (id_flush),
        .valid_i    (if_valid),
        .insn_i     (if_insn),
        .pc_i       (if_pc),
        .intr_i     (if_intr),
        .valid_o    (id_valid),
        .insn_o     (id_insn),
        .pc_o       (id_pc),
        .intr_o     (id_intr),
        .rd_addr_o  (id_rd_addr),
        .rs1_addr_o (id_rs1_addr)
    );

    ex_stage ex_stage_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .step_i     (ex_step),
        .valid_i    (id_valid),
        .insn_i     (id_insn),
        .pc_i       (id_pc),
        .intr_i     (id_intr),
        .rd_addr_i  (id_rd_addr),
        .rs1_addr_i (id_rs1_addr),
        .valid_o    (ex_valid),
        .insn_o     (ex_insn),
        .pc_o       (ex_pc),
        .intr_o     (ex_intr),
        .rd_addr_o  (ex_rd_addr),
        .rs1_addr_o (ex_rs1_addr),
        .trap_o     (ex_trap)
    );

    wb_stage wb_stage_inst (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .step_i     (wb_step),
        .valid_i    (ex_valid),
        .insn_i     (ex_insn),
        .pc_i       (ex_pc),
        .intr_i     (ex_intr),
        .rd_addr_i  (ex_rd_addr),
        .rs1_addr_i (ex_rs1_addr),
        .trap_i     (ex_trap),
        .valid_o    (wb_valid),
        .order_o    (out_order_o),
        .insn_o     (out_insn_o),
        .pc_o       (out_pc_o),
        .intr_o     (out_intr_o),
        .rd_addr_o  (out_rd_addr_o),
        .rs1_addr_o (out_rs1_addr_o),
        .trap_o     (out_trap_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_pipeline_shell.sv
// **********************************************************************
// Directed testbench for the trace pipeline shell with a reference
// queue; run it as the top module over the whole file list
// **********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_shell;

    import shell_trace_pkg::*;

    localparam int SEND_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 500;

    // Field order matches the concatenation of the DUT outputs below
    typedef struct packed {
        order_t    order;
        insn_t     insn;
        pc_t       pc;
        reg_addr_t rd;
        reg_addr_t rs1;
        logic      trap;
        logic      intr;
    } rec_t;

    logic      clk_i;
    logic      arst_n_i;
    logic      in_valid_i;
    logic      in_ready_o;
    insn_t     in_insn_i;
    pc_t       in_pc_i;
    logic      irq_i;
    logic      irq_ack_o;
    logic      out_valid_o;
    logic      out_ready_i;
    order_t    out_order_o;
    insn_t     out_insn_o;
    pc_t       out_pc_o;
    reg_addr_t out_rd_addr_o;
    reg_addr_t out_rs1_addr_o;
    logic      out_trap_o;
    logic      out_intr_o;

    rec_t        exp_q[$];
    order_t      next_order;
    logic        trap_pending;
    order_t      trap_order;
    logic        irq_pending;
    logic        irq_prev;
    logic        held;
    rec_t        held_rec;
    int          cycle;
    int          ack_seen;
    int          intr_seen;
    integer      seed;
    logic        sink_ready;
    logic        random_bp;
    logic        bp_random_now;
    logic        bp_ready_now;
    logic [31:0] bp_rnd;
    pc_t         next_pc;

    pipeline_shell pipeline_shell_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_insn_i      (in_insn_i),
        .in_pc_i        (in_pc_i),
        .irq_i          (irq_i),
        .irq_ack_o      (irq_ack_o),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .out_order_o    (out_order_o),
        .out_insn_o     (out_insn_o),
        .out_pc_o       (out_pc_o),
        .out_rd_addr_o  (out_rd_addr_o),
        .out_rs1_addr_o (out_rs1_addr_o),
        .out_trap_o     (out_trap_o),
        .out_intr_o     (out_intr_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic halt_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_insn(input string name, input insn_t exp, input insn_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic compare_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic compare_reg_addr(input string name, input reg_addr_t exp,
                                    input reg_addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic compare_order(input string name, input order_t exp, input order_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic check_outputs(input rec_t rec);
        compare_order("out_order_o", rec.order, out_order_o);
        compare_insn("out_insn_o", rec.insn, out_insn_o);
        compare_pc("out_pc_o", rec.pc, out_pc_o);
        compare_reg_addr("out_rd_addr_o", rec.rd, out_rd_addr_o);
        compare_reg_addr("out_rs1_addr_o", rec.rs1, out_rs1_addr_o);
        compare_flag("out_trap_o", rec.trap, out_trap_o);
        compare_flag("out_intr_o", rec.intr, out_intr_o);
    endtask

    // The rd field sits at bits 11:7 and rs1 at bits 19:15, and an
    // instruction whose low bits are not 11 traps and writes no register
    function automatic rec_t predict_record(input insn_t insn, input pc_t pc,
                                            input logic intr, input order_t order);
        rec_t rec;
        rec.order = order;
        rec.insn  = insn;
        rec.pc    = pc;
        rec.trap  = (insn[1:0] != 2'b11);
        rec.rd    = rec.trap ? 5'd0 : insn[11:7];
        rec.rs1   = insn[19:15];
        rec.intr  = intr;
        return rec;
    endfunction

    function automatic insn_t make_insn(input logic [1:0] low);
        insn_t w;
        w      = $random(seed);
        w[1:0] = low;
        return w;
    endfunction

    // Sink ready is taken from the test flags at the edge and driven just after it
    always @(posedge clk_i) begin
        bp_random_now = random_bp;
        bp_ready_now  = sink_ready;
        bp_rnd        = $random(seed);
        #1;
        out_ready_i = bp_random_now ? bp_rnd[0] : bp_ready_now;
    end

    // Reference model and output checks; every input and output is stable
    // at the falling edge, and handshakes complete at the next rising edge
    always @(negedge clk_i) begin
        rec_t rec;
        logic accept;
        if (arst_n_i) begin
            cycle  = cycle + 1;
            accept = in_valid_i && in_ready_o;
            if (held) begin
                compare_flag("out_valid_o", 1'b1, out_valid_o);
                check_outputs(held_rec);
                held = 1'b0;
            end
            compare_flag("irq_ack_o", irq_pending && accept, irq_ack_o);
            if (irq_ack_o) begin
                ack_seen = ack_seen + 1;
            end
            // Once the trap is on the outputs, new records survive again
            if (trap_pending && out_valid_o && out_order_o == trap_order) begin
                trap_pending = 1'b0;
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("A record with PC 0x%h retired but none was expected", out_pc_o);
                    halt_with_failure();
                end
                rec = exp_q.pop_front();
                check_outputs(rec);
                if (out_intr_o) begin
                    intr_seen = intr_seen + 1;
                end
            end else if (out_valid_o) begin
                held     = 1'b1;
                held_rec = {out_order_o, out_insn_o, out_pc_o, out_rd_addr_o,
                            out_rs1_addr_o, out_trap_o, out_intr_o};
            end
            // Records behind an unretired trap are killed and get no number
            if (accept && !trap_pending) begin
                rec = predict_record(in_insn_i, in_pc_i, irq_pending, next_order);
                exp_q.push_back(rec);
                if (rec.trap) begin
                    trap_pending = 1'b1;
                    trap_order   = next_order;
                end
                next_order = next_order + 16'd1;
            end
            if (irq_pending) begin
                if (accept) begin
                    irq_pending = 1'b0;
                end
            end else if (irq_i && !irq_prev) begin
                irq_pending = 1'b1;
            end
            irq_prev = irq_i;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic send_record(input insn_t insn);
        int   waited;
        logic taken;
        waited     = 0;
        taken      = 1'b0;
        in_valid_i = 1'b1;
        in_insn_i  = insn;
        in_pc_i    = next_pc;
        next_pc    = next_pc + 32'd4;
        while (!taken) begin
            @(negedge clk_i);
            taken = in_ready_o;
            @(posedge clk_i);
            #1;
            waited = waited + 1;
            if (!taken && waited >= SEND_TIMEOUT) begin
                $display("Record with PC 0x%h was not accepted in time", in_pc_i);
                halt_with_failure();
            end
        end
        in_valid_i = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #1;
            waited = waited + 1;
            if (waited >= DRAIN_TIMEOUT) begin
                $display("%0d expected records did not retire in time", exp_q.size());
                halt_with_failure();
            end
        end
        // Quiet time so that a stray record still shows up at the output
        idle_cycles(6);
    endtask

    task automatic test_reset_and_single();
        int waits;
        compare_flag("in_ready_o", 1'b1, in_ready_o);
        compare_flag("out_valid_o", 1'b0, out_valid_o);
        compare_flag("irq_ack_o", 1'b0, irq_ack_o);
        send_record(make_insn(2'b11));
        // Count rising edges from acceptance up to the edge that retires it
        waits = 1;
        @(negedge clk_i);
        while (!(out_valid_o && out_ready_i)) begin
            waits = waits + 1;
            if (waits > 20) begin
                $display("The single record never reached the output");
                halt_with_failure();
            end
            @(negedge clk_i);
        end
        if (waits != 4) begin
            $display("Latency from acceptance to retirement was %0d cycles, not 4", waits);
            halt_with_failure();
        end
        wait_for_drain();
    endtask

    task automatic test_back_to_back();
        int start;
        start = cycle;
        for (int i = 0; i < 20; i++) begin
            send_record(make_insn(2'b11));
        end
        if (cycle - start != 20) begin
            $display("The stream of 20 records was not accepted back to back");
            halt_with_failure();
        end
        wait_for_drain();
    endtask

    task automatic test_random_backpressure();
        random_bp = 1'b1;
        for (int i = 0; i < 40; i++) begin
            if (i % 7 == 3) begin
                idle_cycles(2);
            end
            send_record(make_insn(2'b11));
        end
        random_bp = 1'b0;
        wait_for_drain();
    endtask

    task automatic test_trap_flush();
        // With a free-running sink the records right behind the trap are killed
        send_record(make_insn(2'b11));
        send_record(make_insn(2'b01));
        for (int i = 0; i < 3; i++) begin
            send_record(make_insn(2'b11));
        end
        wait_for_drain();
        // Stalled sink keeps the trap in EX for several cycles
        sink_ready = 1'b0;
        fork
            begin
                send_record(make_insn(2'b11));
                send_record(make_insn(2'b10));
                for (int i = 0; i < 3; i++) begin
                    send_record(make_insn(2'b11));
                end
            end
            begin
                idle_cycles(12);
                sink_ready = 1'b1;
            end
        join
        wait_for_drain();
    endtask

    task automatic test_interrupt_mark();
        int acks_before;
        int marks_before;
        acks_before  = ack_seen;
        marks_before = intr_seen;
        irq_i = 1'b1;
        idle_cycles(2);
        for (int i = 0; i < 3; i++) begin
            send_record(make_insn(2'b11));
        end
        irq_i = 1'b0;
        idle_cycles(2);
        send_record(make_insn(2'b11));
        irq_i = 1'b1;
        idle_cycles(2);
        send_record(make_insn(2'b11));
        irq_i = 1'b0;
        idle_cycles(2);
        // Edge seen in the same cycle as an acceptance marks the next record
        irq_i = 1'b1;
        send_record(make_insn(2'b11));
        send_record(make_insn(2'b11));
        irq_i = 1'b0;
        wait_for_drain();
        if (ack_seen - acks_before != 3 || intr_seen - marks_before != 3) begin
            $display("Saw %0d acknowledges and %0d marked records instead of 3 each",
                     ack_seen - acks_before, intr_seen - marks_before);
            halt_with_failure();
        end
    endtask

    initial begin
        seed         = 44942;
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        in_valid_i   = 1'b0;
        in_insn_i    = '0;
        in_pc_i      = '0;
        irq_i        = 1'b0;
        out_ready_i  = 1'b1;
        sink_ready   = 1'b1;
        random_bp    = 1'b0;
        next_pc      = 32'h0000_1000;
        next_order   = '0;
        trap_pending = 1'b0;
        trap_order   = '0;
        irq_pending  = 1'b0;
        irq_prev     = 1'b0;
        held         = 1'b0;
        held_rec     = '0;
        cycle        = 0;
        ack_seen     = 0;
        intr_seen    = 0;
        repeat (10) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        test_reset_and_single();
        test_back_to_back();
        test_random_backpressure();
        test_trap_flush();
        test_interrupt_mark();
        if (exp_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d expected records never retired", exp_q.size());
            halt_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- pipeline_shell.f
src/shell_cfg_pkg.sv
src/shell_trace_pkg.sv
src/controller.sv
src/if_stage.sv
src/id_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/pipeline_shell.sv
verif/tb_pipeline_shell.sv

//--- Makefile
# Verilator build and run of the trace pipeline shell testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_pipeline_shell
RTL_TOP    ?= pipeline_shell
FILELIST   ?= pipeline_shell.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation passed

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
